/* Bender.yml */
package:
  name: tl_cache_link

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/tl_pkg.sv
      - rtl/tl_link_if.sv
      - rtl/tl_rr_arbiter.sv
      - rtl/tl_sink_alloc.sv
      - rtl/tl_ram_terminator.sv
      - rtl/tl_mem_device.sv
      - rtl/tl_cache_link_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tl_cache_link_asserts.sv
      - test/tl_cache_link_tb.sv

/* list.f */
+incdir+rtl
rtl/tl_pkg.sv
rtl/tl_link_if.sv
rtl/tl_rr_arbiter.sv
rtl/tl_sink_alloc.sv
rtl/tl_ram_terminator.sv
rtl/tl_mem_device.sv
rtl/tl_cache_link_top.sv
test/tl_cache_link_asserts.sv
test/tl_cache_link_tb.sv

/* rtl/tl_cache_link_top.sv */
`timescale 1ns/100ps

`include "tl_params.svh"

module tl_cache_link_top import tl_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Host A
  input  logic                      host_a_valid_i,
  output logic                      host_a_ready_o,
  input  logic [2:0]                host_a_opcode_i,
  input  logic [2:0]                host_a_param_i,
  input  logic [`TL_SIZE_W-1:0]     host_a_size_i,
  input  logic [`TL_HOST_SRC_W-1:0] host_a_source_i,
  input  logic [`TL_ADDR_W-1:0]     host_a_address_i,
  input  logic [`TL_STRB_W-1:0]     host_a_mask_i,
  input  logic [`TL_DATA_W-1:0]     host_a_data_i,
  // Host C
  input  logic                      host_c_valid_i,
  output logic                      host_c_ready_o,
  input  logic [2:0]                host_c_opcode_i,
  input  logic [`TL_SIZE_W-1:0]     host_c_size_i,
  input  logic [`TL_HOST_SRC_W-1:0] host_c_source_i,
  input  logic [`TL_ADDR_W-1:0]     host_c_address_i,
  input  logic [`TL_DATA_W-1:0]     host_c_data_i,
  // Host D
  output logic                      host_d_valid_o,
  input  logic                      host_d_ready_i,
  output logic [2:0]                host_d_opcode_o,
  output logic [2:0]                host_d_param_o,
  output logic [`TL_SIZE_W-1:0]     host_d_size_o,
  output logic [`TL_HOST_SRC_W-1:0] host_d_source_o,
  output logic [`TL_SINK_W-1:0]     host_d_sink_o,
  output logic                      host_d_denied_o,
  output logic [`TL_DATA_W-1:0]     host_d_data_o,
  // Host E, always accepted
  input  logic                      host_e_valid_i,
  input  logic [`TL_SINK_W-1:0]     host_e_sink_i
);

  host_a_t host_a;
  host_c_t host_c;
  host_d_t host_d;

  assign host_a = '{opcode: tl_a_op_e'(host_a_opcode_i), param: host_a_param_i,
                    size: host_a_size_i, source: host_a_source_i,
                    address: host_a_address_i, mask: host_a_mask_i, data: host_a_data_i};

  assign host_c = '{opcode: tl_c_op_e'(host_c_opcode_i), size: host_c_size_i,
                    source: host_c_source_i, address: host_c_address_i,
                    data: host_c_data_i};

  assign host_d_opcode_o = host_d.opcode;
  assign host_d_param_o  = host_d.param;
  assign host_d_size_o   = host_d.size;
  assign host_d_source_o = host_d.source;
  assign host_d_sink_o   = host_d.sink;
  assign host_d_denied_o = host_d.denied;
  assign host_d_data_o   = host_d.data;

  tl_link_if u_link ();

  tl_ram_terminator u_terminator (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .host_a_valid_i (host_a_valid_i),
    .host_a_i       (host_a),
    .host_a_ready_o (host_a_ready_o),
    .host_c_valid_i (host_c_valid_i),
    .host_c_i       (host_c),
    .host_c_ready_o (host_c_ready_o),
    .host_d_valid_o (host_d_valid_o),
    .host_d_o       (host_d),
    .host_d_ready_i (host_d_ready_i),
    .host_e_valid_i (host_e_valid_i),
    .host_e_sink_i  (host_e_sink_i),
    .dev            (u_link.host)
  );

  tl_mem_device u_mem (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .link   (u_link.device)
  );

endmodule

/* rtl/tl_link_if.sv */
`timescale 1ns/100ps

// Uncached link between the terminator and the memory
interface tl_link_if import tl_pkg::*; ();

  logic   a_valid;
  logic   a_ready;
  dev_a_t a_bits;

  logic   d_valid;
  logic   d_ready;
  dev_d_t d_bits;

  modport host (
    output a_valid, a_bits, d_ready,
    input  a_ready, d_valid, d_bits
  );

  modport device (
    input  a_valid, a_bits, d_ready,
    output a_ready, d_valid, d_bits
  );

endinterface

/* rtl/tl_mem_device.sv */
`timescale 1ns/100ps

`include "tl_params.svh"

module tl_mem_device import tl_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  tl_link_if.device link
);

  localparam int unsigned OffW = $clog2(`TL_STRB_W);
  localparam int unsigned IdxW = $clog2(`TL_MEM_WORDS);

  logic [`TL_DATA_W-1:0] mem_q [`TL_MEM_WORDS];
  logic [IdxW-1:0]       idx;
  logic                  is_get;
  logic                  accept;
  logic                  rsp_valid_q;
  dev_d_t                rsp_q;

  // Address bits above the byte offset, upper bits wrap
  assign idx    = link.a_bits.address[OffW +: IdxW];
  assign is_get = link.a_bits.opcode == Get;

  // Take a new request when the response slot is free or draining
  assign link.a_ready = !rsp_valid_q || link.d_ready;
  assign accept       = link.a_valid && link.a_ready;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (!is_get) begin
        for (int b = 0; b < `TL_STRB_W; b++) begin
          if (link.a_bits.mask[b]) begin
            mem_q[idx][8*b +: 8] <= link.a_bits.data[8*b +: 8];
          end
        end
      end
      rsp_q.size   <= link.a_bits.size;
      rsp_q.source <= link.a_bits.source;
      rsp_q.denied <= 1'b0;
      if (is_get) begin
        rsp_q.opcode <= AccessAckData;
        rsp_q.data   <= mem_q[idx];
      end else begin
        rsp_q.opcode <= AccessAck;
        rsp_q.data   <= '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (link.d_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  assign link.d_valid = rsp_valid_q;
  assign link.d_bits  = rsp_q;

endmodule

/* rtl/tl_params.svh */
`ifndef TL_PARAMS_SVH
`define TL_PARAMS_SVH

// Bus geometry, one beat carries the largest message
`define TL_DATA_W 64
`define TL_STRB_W 8
`define TL_ADDR_W 16
`define TL_SIZE_W 3

// Source and sink identifiers
`define TL_HOST_SRC_W 2
// Top two device source bits hold the translation tag
`define TL_DEV_SRC_W (`TL_HOST_SRC_W + 2)
`define TL_SINK_W 2

// Backing memory depth in bus words
`define TL_MEM_WORDS 256

`endif

/* rtl/tl_pkg.sv */
`include "tl_params.svh"

package tl_pkg;

  typedef enum logic [2:0] {
    PutFullData    = 3'd0,
    PutPartialData = 3'd1,
    Get            = 3'd4,
    AcquireBlock   = 3'd6,
    AcquirePerm    = 3'd7
  } tl_a_op_e;

  typedef enum logic [2:0] {
    Release     = 3'd6,
    ReleaseData = 3'd7
  } tl_c_op_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'd0,
    AccessAckData = 3'd1,
    Grant         = 3'd4,
    GrantData     = 3'd5,
    ReleaseAck    = 3'd6
  } tl_d_op_e;

  // Grow param on Acquire
  typedef enum logic [2:0] {
    NtoB = 3'd0,
    NtoT = 3'd1,
    BtoT = 3'd2
  } tl_grow_e;

  // Cap param on Grant, only trunk is ever handed out
  typedef enum logic [2:0] {
    toT = 3'd0
  } tl_cap_e;

  // Kept in the top two device source bits
  typedef enum logic [1:0] {
    TagPlain = 2'b00,
    TagAcq   = 2'b01,
    TagRel   = 2'b11
  } tl_tag_e;

  typedef struct packed {
    tl_a_op_e                  opcode;
    logic [2:0]                param;
    logic [`TL_SIZE_W-1:0]     size;
    logic [`TL_HOST_SRC_W-1:0] source;
    logic [`TL_ADDR_W-1:0]     address;
    logic [`TL_STRB_W-1:0]     mask;
    logic [`TL_DATA_W-1:0]     data;
  } host_a_t;

  typedef struct packed {
    tl_c_op_e                  opcode;
    logic [`TL_SIZE_W-1:0]     size;
    logic [`TL_HOST_SRC_W-1:0] source;
    logic [`TL_ADDR_W-1:0]     address;
    logic [`TL_DATA_W-1:0]     data;
  } host_c_t;

  typedef struct packed {
    tl_d_op_e                  opcode;
    logic [2:0]                param;
    logic [`TL_SIZE_W-1:0]     size;
    logic [`TL_HOST_SRC_W-1:0] source;
    logic [`TL_SINK_W-1:0]     sink;
    logic                      denied;
    logic [`TL_DATA_W-1:0]     data;
  } host_d_t;

  typedef struct packed {
    tl_a_op_e                 opcode;
    logic [2:0]               param;
    logic [`TL_SIZE_W-1:0]    size;
    logic [`TL_DEV_SRC_W-1:0] source;
    logic [`TL_ADDR_W-1:0]    address;
    logic [`TL_STRB_W-1:0]    mask;
    logic [`TL_DATA_W-1:0]    data;
  } dev_a_t;

  typedef struct packed {
    tl_d_op_e                 opcode;
    logic [`TL_SIZE_W-1:0]    size;
    logic [`TL_DEV_SRC_W-1:0] source;
    logic                     denied;
    logic [`TL_DATA_W-1:0]    data;
  } dev_d_t;

endpackage

/* rtl/tl_ram_terminator.sv */
`timescale 1ns/100ps

`include "tl_params.svh"

module tl_ram_terminator import tl_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  host_a_valid_i,
  input  host_a_t               host_a_i,
  output logic                  host_a_ready_o,
  input  logic                  host_c_valid_i,
  input  host_c_t               host_c_i,
  output logic                  host_c_ready_o,
  output logic                  host_d_valid_o,
  output host_d_t               host_d_o,
  input  logic                  host_d_ready_i,
  input  logic                  host_e_valid_i,
  input  logic [`TL_SINK_W-1:0] host_e_sink_i,
  tl_link_if.host               dev
);

  localparam int unsigned HostSrcW = `TL_HOST_SRC_W;
  localparam int unsigned OffW     = $clog2(`TL_STRB_W);

  // Byte mask of an aligned access of 2**size bytes
  function automatic logic [`TL_STRB_W-1:0] byte_mask(
    input logic [OffW-1:0]       addr,
    input logic [`TL_SIZE_W-1:0] size
  );
    int unsigned           nbytes;
    logic [`TL_STRB_W-1:0] ones;
    nbytes = (size >= OffW) ? `TL_STRB_W : (1 << size);
    ones   = (nbytes >= `TL_STRB_W) ? '1 : `TL_STRB_W'((1 << nbytes) - 1);
    return ones << (addr & ~(nbytes - 1));
  endfunction

  // Device A requesters: 0 acquire path, 1 release path
  logic   [1:0] dev_a_req_valid;
  logic   [1:0] dev_a_req_ready;
  dev_a_t [1:0] dev_a_req_bits;
  dev_a_t       acq_a;
  dev_a_t       rel_a;

  // Host D requesters: 0 device response, 1 local Grant, 2 local ReleaseAck
  logic    [2:0] d_req_valid;
  logic    [2:0] d_req_ready;
  host_d_t [2:0] d_req_bits;
  host_d_t       rsp_d;
  host_d_t       gnt_d;
  host_d_t       rack_d;

  logic    d_arb_valid;
  logic    d_arb_ready;
  host_d_t d_arb_bits;
  logic    local_grant;

  //////////////////////////////////////////////////////////////////////
  // Acquire path

  assign local_grant = host_a_i.opcode == AcquirePerm ||
                       (host_a_i.opcode == AcquireBlock && host_a_i.param == BtoT);

  assign dev_a_req_valid[0] = host_a_valid_i && !local_grant;
  assign d_req_valid[1]     = host_a_valid_i && local_grant;
  assign host_a_ready_o     = local_grant ? d_req_ready[1] : dev_a_req_ready[0];

  always_comb begin
    acq_a = '{opcode: host_a_i.opcode, param: '0, size: host_a_i.size,
              source: {TagPlain, host_a_i.source}, address: host_a_i.address,
              mask: host_a_i.mask, data: host_a_i.data};
    // Block fetch becomes a plain read, GrantData is rebuilt on the way back
    if (host_a_i.opcode == AcquireBlock) begin
      acq_a.opcode = Get;
      acq_a.source = {TagAcq, host_a_i.source};
    end
  end

  assign gnt_d = '{opcode: Grant, param: toT, size: host_a_i.size,
                   source: host_a_i.source, sink: '0, denied: 1'b0, data: '0};

  //////////////////////////////////////////////////////////////////////
  // Release path

  assign dev_a_req_valid[1] = host_c_valid_i && host_c_i.opcode == ReleaseData;
  assign d_req_valid[2]     = host_c_valid_i && host_c_i.opcode == Release;
  assign host_c_ready_o     = (host_c_i.opcode == Release) ? d_req_ready[2]
                                                           : dev_a_req_ready[1];

  assign rel_a = '{opcode: PutFullData, param: '0, size: host_c_i.size,
                   source: {TagRel, host_c_i.source}, address: host_c_i.address,
                   mask: byte_mask(host_c_i.address[OffW-1:0], host_c_i.size),
                   data: host_c_i.data};

  assign rack_d = '{opcode: ReleaseAck, param: '0, size: host_c_i.size,
                    source: host_c_i.source, sink: '0, denied: 1'b0, data: '0};

  //////////////////////////////////////////////////////////////////////
  // Response path

  assign d_req_valid[0] = dev.d_valid;
  assign dev.d_ready    = d_req_ready[0];

  always_comb begin
    rsp_d = '{opcode: dev.d_bits.opcode, param: '0, size: dev.d_bits.size,
              source: dev.d_bits.source[HostSrcW-1:0], sink: '0,
              denied: dev.d_bits.denied, data: dev.d_bits.data};
    case (dev.d_bits.source[HostSrcW +: 2])
      TagAcq: begin
        rsp_d.opcode = GrantData;
        rsp_d.param  = toT;
      end
      TagRel:  rsp_d.opcode = ReleaseAck;
      default: ;
    endcase
  end

  assign dev_a_req_bits = {rel_a, acq_a};
  assign d_req_bits     = {rack_d, gnt_d, rsp_d};

  tl_rr_arbiter #(
    .N         (2),
    .payload_t (dev_a_t)
  ) u_dev_a_arb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (dev_a_req_valid),
    .req_bits_i  (dev_a_req_bits),
    .req_ready_o (dev_a_req_ready),
    .out_valid_o (dev.a_valid),
    .out_bits_o  (dev.a_bits),
    .out_ready_i (dev.a_ready)
  );

  tl_rr_arbiter #(
    .N         (3),
    .payload_t (host_d_t)
  ) u_host_d_arb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (d_req_valid),
    .req_bits_i  (d_req_bits),
    .req_ready_o (d_req_ready),
    .out_valid_o (d_arb_valid),
    .out_bits_o  (d_arb_bits),
    .out_ready_i (d_arb_ready)
  );

  tl_sink_alloc u_sink_alloc (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (d_arb_valid),
    .in_bits_i   (d_arb_bits),
    .in_ready_o  (d_arb_ready),
    .out_valid_o (host_d_valid_o),
    .out_bits_o  (host_d_o),
    .out_ready_i (host_d_ready_i),
    .ack_valid_i (host_e_valid_i),
    .ack_sink_i  (host_e_sink_i)
  );

endmodule

/* rtl/tl_rr_arbiter.sv */
`timescale 1ns/100ps

module tl_rr_arbiter #(
  parameter int unsigned N = 2,
  parameter type payload_t = logic
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic     [N-1:0]     req_valid_i,
  input  payload_t [N-1:0]     req_bits_i,
  output logic     [N-1:0]     req_ready_o,
  output logic                 out_valid_o,
  output payload_t             out_bits_o,
  input  logic                 out_ready_i
);

  localparam int unsigned IdxW = (N > 1) ? $clog2(N) : 1;

  logic [IdxW-1:0] ptr_q;
  logic [IdxW-1:0] hold_q;
  logic            hold_valid_q;
  logic [IdxW-1:0] pick;
  logic [IdxW-1:0] sel;
  logic            found;

  // First valid requester at or after the pointer
  always_comb begin
    int idx;
    pick  = ptr_q;
    found = 1'b0;
    for (int i = 0; i < N; i++) begin
      idx = (int'(ptr_q) + i) % N;
      if (!found && req_valid_i[idx]) begin
        pick  = IdxW'(idx);
        found = 1'b1;
      end
    end
  end

  // A stalled grant keeps its requester until it transfers
  assign sel         = hold_valid_q ? hold_q : pick;
  assign out_valid_o = req_valid_i[sel];
  assign out_bits_o  = req_bits_i[sel];

  for (genvar i = 0; i < N; i++) begin : g_ready
    assign req_ready_o[i] = out_ready_i && (sel == IdxW'(i));
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q        <= '0;
      hold_q       <= '0;
      hold_valid_q <= 1'b0;
    end else if (out_valid_o && out_ready_i) begin
      ptr_q        <= (sel == IdxW'(N - 1)) ? '0 : sel + 1'b1;
      hold_valid_q <= 1'b0;
    end else if (out_valid_o) begin
      hold_q       <= sel;
      hold_valid_q <= 1'b1;
    end
  end

endmodule

/* rtl/tl_sink_alloc.sv */
`timescale 1ns/100ps

`include "tl_params.svh"

module tl_sink_alloc import tl_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  in_valid_i,
  input  host_d_t               in_bits_i,
  output logic                  in_ready_o,
  output logic                  out_valid_o,
  output host_d_t               out_bits_o,
  input  logic                  out_ready_i,
  input  logic                  ack_valid_i,
  input  logic [`TL_SINK_W-1:0] ack_sink_i
);

  localparam int unsigned Sinks = 1 << `TL_SINK_W;

  logic [Sinks-1:0]      free_q;
  logic [Sinks-1:0]      free_d;
  logic [`TL_SINK_W-1:0] free_idx;
  logic                  any_free;
  logic                  is_grant;
  logic                  block;

  // Lowest free identifier wins
  always_comb begin
    free_idx = '0;
    any_free = 1'b0;
    for (int i = Sinks - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        free_idx = `TL_SINK_W'(i);
        any_free = 1'b1;
      end
    end
  end

  assign is_grant = in_bits_i.opcode inside {Grant, GrantData};
  assign block    = is_grant && !any_free;

  // Hold the grant off entirely while the pool is empty
  assign out_valid_o = in_valid_i && !block;
  assign in_ready_o  = out_ready_i && !block;

  always_comb begin
    out_bits_o      = in_bits_i;
    out_bits_o.sink = is_grant ? free_idx : '0;
  end

  always_comb begin
    free_d = free_q;
    if (out_valid_o && out_ready_i && is_grant) begin
      free_d[free_idx] = 1'b0;
    end
    if (ack_valid_i) begin
      free_d[ack_sink_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      free_q <= '1;
    end else begin
      free_q <= free_d;
    end
  end

endmodule

/* test/tl_cache_link_asserts.sv */
`timescale 1ns/100ps

`include "tl_params.svh"

module tl_cache_link_asserts import tl_pkg::*; (
  input logic                                                clk_i,
  input logic                                                rst_ni,
  input logic                                                host_d_valid_i,
  input logic                                                host_d_ready_i,
  input logic [6+`TL_SIZE_W+`TL_HOST_SRC_W+`TL_DATA_W:0]     host_d_fields_i,
  input logic                                                dev_a_valid_i,
  input logic                                                dev_a_ready_i,
  input dev_a_t                                              dev_a_bits_i
);

  int fail_cnt = 0;

  // Sink is left out, it may drop to a lower identifier freed during the stall
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_d_valid_i && !host_d_ready_i |=> host_d_valid_i && $stable(host_d_fields_i))
  else begin
    fail_cnt++;
    $error("host D payload changed or dropped while stalled");
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    dev_a_valid_i && !dev_a_ready_i |=> dev_a_valid_i && $stable(dev_a_bits_i))
  else begin
    fail_cnt++;
    $error("device A payload changed or dropped while stalled");
  end

  assert property (@(posedge clk_i) !rst_ni |-> !host_d_valid_i)
  else begin
    fail_cnt++;
    $error("host D valid high during reset");
  end

endmodule

bind tl_cache_link_top tl_cache_link_asserts u_asserts (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .host_d_valid_i  (host_d_valid_o),
  .host_d_ready_i  (host_d_ready_i),
  .host_d_fields_i ({host_d_opcode_o, host_d_param_o, host_d_size_o, host_d_source_o,
                     host_d_denied_o, host_d_data_o}),
  .dev_a_valid_i   (u_link.a_valid),
  .dev_a_ready_i   (u_link.a_ready),
  .dev_a_bits_i    (u_link.a_bits)
);

/* test/tl_cache_link_tb.sv */
`timescale 1ns/100ps

`include "tl_params.svh"

module tl_cache_link_tb import tl_pkg::*; ();

  localparam int   ClkPeriod   = 40;
  localparam int   SampleDelay = 5;
  localparam int   ResetCycles = 16;
  localparam int   Rows        = 22;
  localparam int   TimeoutCycles = Rows * 40 + ResetCycles;
  localparam int   StallCycles = 20;
  localparam int   StallSink   = 2;
  localparam logic ChanA       = 1'b0;
  localparam logic ChanC       = 1'b1;

  typedef struct packed {
    logic        chan;
    logic [2:0]  opcode;
    logic [2:0]  param;
    logic [2:0]  size;
    logic [1:0]  source;
    logic [15:0] addr;
    logic [7:0]  mask;
    logic [63:0] data;
    logic        send_e;
    logic        stall;
    logic [7:0]  grp;
  } row_t;

  logic        clk_i;
  logic        rst_ni;
  logic        host_a_valid_i;
  logic        host_a_ready_o;
  logic [2:0]  host_a_opcode_i;
  logic [2:0]  host_a_param_i;
  logic [2:0]  host_a_size_i;
  logic [1:0]  host_a_source_i;
  logic [15:0] host_a_address_i;
  logic [7:0]  host_a_mask_i;
  logic [63:0] host_a_data_i;
  logic        host_c_valid_i;
  logic        host_c_ready_o;
  logic [2:0]  host_c_opcode_i;
  logic [2:0]  host_c_size_i;
  logic [1:0]  host_c_source_i;
  logic [15:0] host_c_address_i;
  logic [63:0] host_c_data_i;
  logic        host_d_valid_o;
  logic        host_d_ready_i;
  logic [2:0]  host_d_opcode_o;
  logic [2:0]  host_d_param_o;
  logic [2:0]  host_d_size_o;
  logic [1:0]  host_d_source_o;
  logic [1:0]  host_d_sink_o;
  logic        host_d_denied_o;
  logic [63:0] host_d_data_o;
  logic        host_e_valid_i;
  logic [1:0]  host_e_sink_i;

  row_t        rows [Rows];
  logic [63:0] ref_mem [`TL_MEM_WORDS];
  logic [63:0] rnd_state;
  int          a_q [$];
  int          c_q [$];
  int          e_q [$];
  logic [3:0]  free_mask;
  logic [3:0]  out_valid;
  logic [2:0]  exp_op [4];
  logic [2:0]  exp_param [4];
  logic [2:0]  exp_size [4];
  logic [63:0] exp_data [4];
  logic        exp_grant [4];
  logic        exp_e [4];
  int          cycle_cnt = 0;

  tl_cache_link_top u_tl_cache_link_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [63:0] next_random();
    rnd_state = rnd_state ^ (rnd_state << 13);
    rnd_state = rnd_state ^ (rnd_state >> 7);
    rnd_state = rnd_state ^ (rnd_state << 17);
    return rnd_state;
  endfunction

  // Bytes covered by an aligned block of 2**size bytes
  function automatic logic [7:0] release_mask(input logic [15:0] addr, input logic [2:0] size);
    int         nbytes;
    int         base;
    logic [7:0] m;
    nbytes = (size >= 3) ? 8 : (1 << size);
    base   = addr[2:0] - (addr[2:0] % nbytes);
    m      = '0;
    for (int b = 0; b < 8; b++) begin
      m[b] = (b >= base) && (b < base + nbytes);
    end
    return m;
  endfunction

  task automatic write_ref(input int w, input logic [7:0] m, input logic [63:0] d);
    for (int b = 0; b < 8; b++) begin
      if (m[b]) begin
        ref_mem[w][8*b +: 8] = d[8*b +: 8];
      end
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    if (got !== want) begin
      fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, want));
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Expected responses

  task automatic accept_row(input int idx);
    row_t r;
    int   w;
    r = rows[idx];
    w = (r.addr >> 3) % `TL_MEM_WORDS;
    if (out_valid[r.source]) begin
      fail_run("second request accepted on a source that is still busy");
    end
    out_valid[r.source] = 1'b1;
    exp_param[r.source] = '0;
    exp_size[r.source]  = r.size;
    exp_data[r.source]  = '0;
    exp_grant[r.source] = 1'b0;
    exp_e[r.source]     = r.send_e;
    if (r.chan == ChanC) begin
      exp_op[r.source] = ReleaseAck;
      if (r.opcode == ReleaseData) begin
        write_ref(w, release_mask(r.addr, r.size), r.data);
      end
    end else begin
      case (r.opcode)
        Get: begin
          exp_op[r.source]   = AccessAckData;
          exp_data[r.source] = ref_mem[w];
        end
        AcquireBlock, AcquirePerm: begin
          exp_grant[r.source] = 1'b1;
          exp_param[r.source] = toT;
          exp_op[r.source]    = Grant;
          if (r.opcode == AcquireBlock && r.param != BtoT) begin
            exp_op[r.source]   = GrantData;
            exp_data[r.source] = ref_mem[w];
          end
        end
        default: begin
          exp_op[r.source] = AccessAck;
          write_ref(w, r.mask, r.data);
        end
      endcase
    end
  endtask

  task automatic check_beat();
    int src;
    int sink;
    src = host_d_source_o;
    if (!out_valid[src]) begin
      fail_run("D response arrived for a source with no request outstanding");
    end
    check_value("host_d_opcode", host_d_opcode_o, exp_op[src]);
    check_value("host_d_param", host_d_param_o, exp_param[src]);
    check_value("host_d_size", host_d_size_o, exp_size[src]);
    check_value("host_d_denied", host_d_denied_o, 1'b0);
    check_value("host_d_data", host_d_data_o, exp_data[src]);
    sink = 0;
    if (exp_grant[src]) begin
      sink = -1;
      for (int s = 3; s >= 0; s--) begin
        if (free_mask[s]) begin
          sink = s;
        end
      end
      if (sink < 0) begin
        fail_run("grant delivered while every sink was in use");
      end
      free_mask[sink] = 1'b0;
      if (exp_e[src]) begin
        e_q.push_back(sink);
      end
    end
    check_value("host_d_sink", host_d_sink_o, sink);
    out_valid[src] = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////
  // Cycle engine

  task automatic run_cycle();
    row_t        r;
    logic [63:0] rnd;
    @(negedge clk_i);
    host_a_valid_i = a_q.size() > 0;
    if (a_q.size() > 0) begin
      r = rows[a_q[0]];
      host_a_opcode_i  = r.opcode;
      host_a_param_i   = r.param;
      host_a_size_i    = r.size;
      host_a_source_i  = r.source;
      host_a_address_i = r.addr;
      host_a_mask_i    = r.mask;
      host_a_data_i    = r.data;
    end
    host_c_valid_i = c_q.size() > 0;
    if (c_q.size() > 0) begin
      r = rows[c_q[0]];
      host_c_opcode_i  = r.opcode;
      host_c_size_i    = r.size;
      host_c_source_i  = r.source;
      host_c_address_i = r.addr;
      host_c_data_i    = r.data;
    end
    host_e_valid_i = e_q.size() > 0;
    if (e_q.size() > 0) begin
      host_e_sink_i = 2'(e_q[0]);
    end
    rnd = next_random();
    host_d_ready_i = rnd[1:0] != 2'b00;
    #SampleDelay;
    if (u_tl_cache_link_top.u_asserts.fail_cnt != 0) begin
      fail_run("a bound handshake assertion failed");
    end
    // Acceptance first, a local answer beats in the same cycle
    if (host_a_valid_i && host_a_ready_o) begin
      accept_row(a_q.pop_front());
    end
    if (host_c_valid_i && host_c_ready_o) begin
      accept_row(c_q.pop_front());
    end
    if (host_d_valid_o && host_d_ready_i) begin
      check_beat();
    end
    // GrantAck frees its sink for the following cycle
    if (host_e_valid_i) begin
      free_mask[host_e_sink_i] = 1'b1;
      void'(e_q.pop_front());
    end
  endtask

  task automatic run_batch(input int first, input int last);
    logic stall;
    stall = 1'b0;
    for (int k = first; k <= last; k++) begin
      if (rows[k].chan == ChanA) begin
        a_q.push_back(k);
      end else begin
        c_q.push_back(k);
      end
      stall = stall | rows[k].stall;
    end
    // Pool is empty here, the grant must stay off until a sink returns
    if (stall) begin
      repeat (StallCycles) begin
        run_cycle();
        check_value("host_d_valid", host_d_valid_o, 1'b0);
      end
      e_q.push_back(StallSink);
    end
    while (a_q.size() > 0 || c_q.size() > 0 || out_valid != '0 || e_q.size() > 0) begin
      run_cycle();
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      fail_run("timeout, the tests did not finish within the cycle limit");
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    int i;
    int j;
    rst_ni           = 1'b0;
    host_a_valid_i   = 1'b0;
    host_a_opcode_i  = '0;
    host_a_param_i   = '0;
    host_a_size_i    = '0;
    host_a_source_i  = '0;
    host_a_address_i = '0;
    host_a_mask_i    = '0;
    host_a_data_i    = '0;
    host_c_valid_i   = 1'b0;
    host_c_opcode_i  = '0;
    host_c_size_i    = '0;
    host_c_source_i  = '0;
    host_c_address_i = '0;
    host_c_data_i    = '0;
    host_d_ready_i   = 1'b0;
    host_e_valid_i   = 1'b0;
    host_e_sink_i    = '0;
    rnd_state        = 64'd56426;
    free_mask        = 4'hF;
    out_valid        = '0;

    // chan, opcode, param, size, source, addr, mask, data (0 is random), E, stall, group
    rows = '{
      '{ChanA, PutFullData,    3'd0, 3'd3, 2'd0, 16'h0040, 8'hFF, 64'h0, 1'b0, 1'b0, 8'd0},
      '{ChanA, PutPartialData, 3'd0, 3'd3, 2'd1, 16'h0040, 8'h5A,
        64'h0123_4567_89ab_cdef, 1'b0, 1'b0, 8'd1},
      '{ChanA, Get,            3'd0, 3'd3, 2'd2, 16'h0040, 8'hFF, 64'h0, 1'b0, 1'b0, 8'd2},
      '{ChanA, PutFullData,    3'd0, 3'd3, 2'd0, 16'h0080, 8'hFF, 64'h0, 1'b0, 1'b0, 8'd3},
      '{ChanA, AcquireBlock,   NtoT, 3'd3, 2'd1, 16'h0080, 8'hFF, 64'h0, 1'b1, 1'b0, 8'd4},
      '{ChanA, AcquirePerm,    NtoT, 3'd3, 2'd2, 16'h00C0, 8'hFF, 64'h0, 1'b1, 1'b0, 8'd5},
      '{ChanA, AcquireBlock,   BtoT, 3'd3, 2'd3, 16'h0080, 8'hFF, 64'h0, 1'b1, 1'b0, 8'd6},
      '{ChanC, Release,        3'd0, 3'd3, 2'd0, 16'h0100, 8'h00, 64'h0, 1'b0, 1'b0, 8'd7},
      '{ChanC, ReleaseData,    3'd0, 3'd2, 2'd1, 16'h0084, 8'h00, 64'h0, 1'b0, 1'b0, 8'd8},
      '{ChanA, Get,            3'd0, 3'd3, 2'd2, 16'h0080, 8'hFF, 64'h0, 1'b0, 1'b0, 8'd9},
      '{ChanA, PutFullData,    3'd0, 3'd3, 2'd0, 16'h0200, 8'hFF, 64'h0, 1'b0, 1'b0, 8'd10},
      '{ChanA, Get,            3'd0, 3'd3, 2'd2, 16'h0040, 8'hFF, 64'h0, 1'b0, 1'b0, 8'd10},
      '{ChanC, ReleaseData,    3'd0, 3'd3, 2'd1, 16'h0300, 8'h00, 64'h0, 1'b0, 1'b0, 8'd10},
      '{ChanC, Release,        3'd0, 3'd3, 2'd3, 16'h0100, 8'h00, 64'h0, 1'b0, 1'b0, 8'd10},
      '{ChanA, AcquireBlock,   NtoT, 3'd3, 2'd0, 16'h0200, 8'hFF, 64'h0, 1'b1, 1'b0, 8'd11},
      '{ChanA, AcquirePerm,    NtoB, 3'd3, 2'd2, 16'h0240, 8'hFF, 64'h0, 1'b1, 1'b0, 8'd11},
      '{ChanC, ReleaseData,    3'd0, 3'd1, 2'd1, 16'h0302, 8'h00, 64'h0, 1'b0, 1'b0, 8'd11},
      '{ChanA, AcquirePerm,    NtoT, 3'd3, 2'd0, 16'h0400, 8'hFF, 64'h0, 1'b0, 1'b0, 8'd12},
      '{ChanA, AcquirePerm,    NtoT, 3'd3, 2'd1, 16'h0440, 8'hFF, 64'h0, 1'b0, 1'b0, 8'd13},
      '{ChanA, AcquirePerm,    NtoT, 3'd3, 2'd2, 16'h0480, 8'hFF, 64'h0, 1'b0, 1'b0, 8'd14},
      '{ChanA, AcquirePerm,    NtoT, 3'd3, 2'd3, 16'h04C0, 8'hFF, 64'h0, 1'b0, 1'b0, 8'd15},
      '{ChanA, AcquirePerm,    NtoT, 3'd3, 2'd0, 16'h0500, 8'hFF, 64'h0, 1'b0, 1'b1, 8'd16}
    };
    for (int k = 0; k < Rows; k++) begin
      if (rows[k].data == '0) begin
        rows[k].data = next_random();
      end
    end

    repeat (ResetCycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Rows sharing a group are in flight together
    i = 0;
    while (i < Rows) begin
      j = i;
      while (j + 1 < Rows && rows[j + 1].grp == rows[i].grp) begin
        j++;
      end
      run_batch(i, j);
      i = j + 1;
    end

    @(negedge clk_i);
    host_a_valid_i = 1'b0;
    host_c_valid_i = 1'b0;
    host_e_valid_i = 1'b0;
    @(negedge clk_i);
    if (u_tl_cache_link_top.u_asserts.fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
